// ==== design/img_consts.svh ====
`ifndef IMG_CONSTS_SVH
`define IMG_CONSTS_SVH

// Header length in 16-bit words
`define IMG_HEADER_WORDS 4

// Frame geometry assumed by a readout
`define IMG_FRAME_WIDTH  8
`define IMG_FRAME_HEIGHT 4

`define IMG_CHECKSUM_WORDS 2

// Header, pixels and checksum of one stored image
`define IMG_WORD_COUNT (`IMG_HEADER_WORDS + `IMG_FRAME_WIDTH * `IMG_FRAME_HEIGHT + \
                        `IMG_CHECKSUM_WORDS)

// Frame memory organisation
`define IMG_BLOCK_DEPTH 64
`define IMG_BLOCK_COUNT 2

// Top pixel bits that classify highlight or shadow
`define IMG_STAT_MASK_BITS 7

`endif

// ==== design/img_pkg.sv ====
`default_nettype none

`include "img_consts.svh"

package img_pkg;

    // Memory and readout word
    typedef logic [15:0] word_t;

    // One sensor sample
    typedef logic [11:0] pixel_t;

    typedef logic [$clog2(`IMG_BLOCK_COUNT)-1:0] block_t;
    typedef logic [$clog2(`IMG_BLOCK_DEPTH)-1:0] addr_t;

    // Command header, sent most significant word first
    typedef logic [`IMG_HEADER_WORDS*16-1:0] header_t;

    typedef logic [0:0] skip_t;

    // Wide enough to count a full block
    typedef logic [$clog2(`IMG_BLOCK_DEPTH):0] word_count_t;

    typedef logic [17:0] stat_count_t;
    typedef logic [31:0] checksum_t;

endpackage

`default_nettype wire

// ==== design/mem_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One requester's access to the frame memory
interface mem_port_if;
    import img_pkg::*;

    logic   req;
    logic   we;
    block_t block;
    addr_t  addr;
    word_t  wdata;

    // Grant comes in the request cycle, read data one cycle later
    logic   gnt;
    word_t  rdata;

    modport requester (
        output req, we, block, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, block, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// ==== design/fletcher_checksum.sv ====
`timescale 1ns/1ns
`default_nettype none

module fletcher_checksum (
    input  wire logic           clk,
    input  wire logic           clr,
    input  wire logic           en,
    input  wire img_pkg::word_t din,
    output img_pkg::checksum_t  dout
);
    import img_pkg::*;

    word_t sum_a;
    word_t sum_b;
    word_t next_a;

    // Addition modulo 65535, inputs already below the modulus
    function automatic word_t mod_add(input word_t a, input word_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return (s >= 17'd65535) ? word_t'(s - 17'd65535) : s[15:0];
    endfunction

    assign next_a = mod_add(sum_a, din);
    assign dout   = {sum_b, sum_a};

    always_ff @(posedge clk) begin
        if (clr) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            sum_b <= mod_add(sum_b, next_a);
        end
    end

endmodule

`default_nettype wire

// ==== design/capture_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "img_consts.svh"

module capture_writer (
    input  wire logic             clk,
    input  wire logic             readout_rst,
    input  wire logic             cmd_capture,
    input  wire img_pkg::block_t  cmd_ram_block,
    input  wire img_pkg::skip_t   cmd_skip_count,
    input  wire img_pkg::header_t cmd_header,
    input  wire img_pkg::pixel_t  img_d,
    input  wire logic             img_fv,
    input  wire logic             img_lv,
    mem_port_if.requester         mem,
    output logic                  status_capture_done,
    output img_pkg::word_count_t  status_capture_word_count,
    output img_pkg::stat_count_t  status_highlight_count,
    output img_pkg::stat_count_t  status_shadow_count
);
    import img_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LATCH,
        S_CLEAR,
        S_HEADER,
        S_WAIT_FRAME,
        S_SKIP,
        S_PIXELS,
        S_CHECKSUM
    } state_t;

    localparam int HDR_CNT_BITS = $clog2(`IMG_HEADER_WORDS);

    state_t                        state;
    logic                          capture_q;
    skip_t                         skip_left;
    block_t                        blk_q;
    header_t                       header_q;
    logic [HDR_CNT_BITS-1:0]       hdr_cnt;
    addr_t                         addr_q;
    logic                          req_q;
    word_t                         wdata_q;
    logic                          sum_en;
    logic                          cks_hi;
    logic [1:0]                    fin_pipe;
    checksum_t                     cks;

    // Registered pixel port
    pixel_t                        px_d;
    logic                          fv_q;
    logic                          lv_q;
    logic                          fv_prev;
    logic                          lv_prev;
    logic                          frame_start;

    // Subsample position, wraps every four
    logic [1:0]                    col;
    logic [1:0]                    row;
    logic                          stat_en;
    pixel_t                        stat_px;
    logic [`IMG_STAT_MASK_BITS-1:0] stat_top;

    assign mem.req   = req_q;
    assign mem.we    = 1'b1;
    assign mem.block = blk_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    assign frame_start = fv_q && !fv_prev;
    assign stat_top    = stat_px[$bits(pixel_t)-1 -: `IMG_STAT_MASK_BITS];

    // Checksum runs on the little-endian view of header and pixel words
    fletcher_checksum u_checksum (
        .clk  (clk),
        .clr  (!readout_rst || state == S_CLEAR),
        .en   (sum_en && mem.gnt),
        .din  ({wdata_q[7:0], wdata_q[15:8]}),
        .dout (cks)
    );

    always_ff @(posedge clk) begin
        px_d    <= img_d;
        stat_px <= px_d;
    end

    // ==============================
    // Capture sequence
    // ==============================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state                     <= S_IDLE;
            capture_q                 <= 1'b0;
            skip_left                 <= '0;
            blk_q                     <= '0;
            hdr_cnt                   <= '0;
            addr_q                    <= '0;
            req_q                     <= 1'b0;
            sum_en                    <= 1'b0;
            cks_hi                    <= 1'b0;
            fin_pipe                  <= '0;
            fv_q                      <= 1'b0;
            lv_q                      <= 1'b0;
            fv_prev                   <= 1'b0;
            lv_prev                   <= 1'b0;
            col                       <= '0;
            row                       <= '0;
            stat_en                   <= 1'b0;
            status_capture_done       <= 1'b0;
            status_capture_word_count <= '0;
            status_highlight_count    <= '0;
            status_shadow_count       <= '0;
        end else begin
            capture_q <= cmd_capture;
            fv_q      <= img_fv;
            lv_q      <= img_lv;
            fv_prev   <= fv_q;
            lv_prev   <= lv_q;
            req_q     <= 1'b0;
            sum_en    <= 1'b0;
            stat_en   <= (state == S_PIXELS) && lv_q && col == 2'd0 && row == 2'd0;

            col <= lv_q ? col + 2'd1 : 2'd0;
            if (!fv_q) begin
                row <= '0;
            end else if (lv_prev && !lv_q) begin
                row <= row + 2'd1;
            end

            if (req_q && mem.gnt) begin
                addr_q                    <= addr_q + 1'b1;
                status_capture_word_count <= status_capture_word_count + 1'b1;
            end

            if (stat_en) begin
                if (&stat_top) begin
                    status_highlight_count <= status_highlight_count + 1'b1;
                end else if (stat_top == '0) begin
                    status_shadow_count <= status_shadow_count + 1'b1;
                end
            end

            // Done toggles two cycles after the last checksum write
            fin_pipe <= {fin_pipe[0], state == S_CHECKSUM && cks_hi};
            if (fin_pipe[1]) begin
                status_capture_done <= !status_capture_done;
            end

            case (state)
                S_LATCH: begin
                    skip_left <= cmd_skip_count;
                    blk_q     <= cmd_ram_block;
                    state     <= S_CLEAR;
                end
                S_CLEAR: begin
                    status_capture_word_count <= '0;
                    status_highlight_count    <= '0;
                    status_shadow_count       <= '0;
                    addr_q                    <= '0;
                    header_q                  <= cmd_header;
                    hdr_cnt                   <= '0;
                    state                     <= S_HEADER;
                end
                S_HEADER: begin
                    req_q    <= 1'b1;
                    sum_en   <= 1'b1;
                    wdata_q  <= header_q[$bits(header_t)-1 -: $bits(word_t)];
                    header_q <= header_q << $bits(word_t);
                    hdr_cnt  <= hdr_cnt + 1'b1;
                    if (hdr_cnt == HDR_CNT_BITS'(`IMG_HEADER_WORDS - 1)) begin
                        state <= S_WAIT_FRAME;
                    end
                end
                S_WAIT_FRAME: begin
                    if (frame_start) begin
                        state <= (skip_left == '0) ? S_PIXELS : S_SKIP;
                    end
                end
                S_SKIP: begin
                    skip_left <= skip_left - 1'b1;
                    state     <= S_WAIT_FRAME;
                end
                S_PIXELS: begin
                    // Low byte first, high nibble zero-extended
                    req_q   <= lv_q;
                    sum_en  <= lv_q;
                    wdata_q <= {px_d[7:0], 4'b0000, px_d[11:8]};
                    cks_hi  <= 1'b0;
                    if (!fv_q) begin
                        state <= S_CHECKSUM;
                    end
                end
                S_CHECKSUM: begin
                    req_q  <= 1'b1;
                    cks_hi <= 1'b1;
                    if (!cks_hi) begin
                        wdata_q <= {cks[7:0], cks[15:8]};
                    end else begin
                        wdata_q <= {cks[23:16], cks[31:24]};
                        state   <= S_IDLE;
                    end
                end
                default: ;
            endcase

            // A new command restarts the sequence
            if (cmd_capture != capture_q) begin
                state <= S_LATCH;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/readout_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "img_consts.svh"

module readout_reader (
    input  wire logic            clk,
    input  wire logic            readout_rst,
    input  wire logic            cmd_readout,
    input  wire img_pkg::block_t cmd_ram_block,
    mem_port_if.requester        mem,
    output logic                 readout_start,
    output logic                 readout_ready,
    output img_pkg::word_t       readout_data,
    input  wire logic            readout_trigger
);
    import img_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_WAIT,
        R_HOLD
    } state_t;

    state_t      state;
    logic        readout_q;
    block_t      blk_q;
    addr_t       addr_q;
    word_count_t taken;

    // Request held steady until granted
    assign mem.req   = (state == R_REQ);
    assign mem.we    = 1'b0;
    assign mem.block = blk_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state         <= R_IDLE;
            readout_q     <= 1'b0;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            blk_q         <= '0;
            addr_q        <= '0;
            taken         <= '0;
        end else begin
            readout_q <= cmd_readout;

            case (state)
                R_REQ: begin
                    if (mem.gnt) begin
                        state <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    readout_data  <= mem.rdata;
                    readout_ready <= 1'b1;
                    state         <= R_HOLD;
                end
                R_HOLD: begin
                    // Word and address stay put until consumed
                    if (readout_trigger) begin
                        readout_ready <= 1'b0;
                        addr_q        <= addr_q + 1'b1;
                        taken         <= taken + 1'b1;
                        if (taken == word_count_t'(`IMG_WORD_COUNT - 1)) begin
                            state <= R_IDLE;
                        end else begin
                            state <= R_REQ;
                        end
                    end
                end
                default: ;
            endcase

            if (cmd_readout != readout_q) begin
                readout_start <= !readout_start;
                readout_ready <= 1'b0;
                blk_q         <= cmd_ram_block;
                addr_q        <= '0;
                taken         <= '0;
                state         <= R_REQ;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_mem_arbiter (
    input  wire logic            clk,
    input  wire logic            readout_rst,
    mem_port_if.arbiter          wr_port,
    mem_port_if.arbiter          rd_port,
    output logic                 mem_en,
    output logic                 mem_we,
    output img_pkg::block_t      mem_block,
    output img_pkg::addr_t       mem_addr,
    output img_pkg::word_t       mem_wdata,
    input  wire img_pkg::word_t  mem_rdata
);
    logic wr_wins;
    logic rd_owner;

    // Writer has fixed priority so capture never stalls
    assign wr_wins     = wr_port.req;
    assign wr_port.gnt = wr_port.req;
    assign rd_port.gnt = rd_port.req && !wr_wins;
    assign mem_en      = wr_port.req || rd_port.req;

    always_comb begin
        if (wr_wins) begin
            mem_we    = wr_port.we;
            mem_block = wr_port.block;
            mem_addr  = wr_port.addr;
            mem_wdata = wr_port.wdata;
        end else begin
            mem_we    = rd_port.we;
            mem_block = rd_port.block;
            mem_addr  = rd_port.addr;
            mem_wdata = rd_port.wdata;
        end
    end

    // ==============================
    // Read data return
    // ==============================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            rd_owner <= 1'b0;
        end else if (mem_en && !mem_we) begin
            rd_owner <= !wr_wins;
        end
    end

    // Only the owner of the last read sees its data
    assign wr_port.rdata = rd_owner ? '0 : mem_rdata;
    assign rd_port.rdata = rd_owner ? mem_rdata : '0;

endmodule

`default_nettype wire

// ==== design/frame_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "img_consts.svh"

module frame_mem (
    input  wire logic           clk,
    input  wire logic           mem_en,
    input  wire logic           mem_we,
    input  wire img_pkg::block_t mem_block,
    input  wire img_pkg::addr_t mem_addr,
    input  wire img_pkg::word_t mem_wdata,
    output img_pkg::word_t      mem_rdata
);
    import img_pkg::*;

    word_t mem_array [`IMG_BLOCK_COUNT][`IMG_BLOCK_DEPTH];

    // Single port, read registered
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_block][mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem_array[mem_block][mem_addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/img_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module img_controller (
    input  wire logic              clk,
    input  wire logic              readout_rst,
    input  wire logic              cmd_capture,
    input  wire logic              cmd_readout,
    input  wire img_pkg::block_t   cmd_ram_block,
    input  wire img_pkg::skip_t    cmd_skip_count,
    input  wire img_pkg::header_t  cmd_header,
    input  wire img_pkg::pixel_t   img_d,
    input  wire logic              img_fv,
    input  wire logic              img_lv,
    input  wire logic              readout_trigger,
    output logic                   readout_start,
    output logic                   readout_ready,
    output img_pkg::word_t         readout_data,
    output logic                   status_capture_done,
    output img_pkg::word_count_t   status_capture_word_count,
    output img_pkg::stat_count_t   status_highlight_count,
    output img_pkg::stat_count_t   status_shadow_count
);
    import img_pkg::*;

    logic   mem_en;
    logic   mem_we;
    block_t mem_block;
    addr_t  mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;

    mem_port_if wr_if ();
    mem_port_if rd_if ();

    // ==============================
    // Peers on the frame memory
    // ==============================
    capture_writer u_writer (
        .clk                       (clk),
        .readout_rst               (readout_rst),
        .cmd_capture               (cmd_capture),
        .cmd_ram_block             (cmd_ram_block),
        .cmd_skip_count            (cmd_skip_count),
        .cmd_header                (cmd_header),
        .img_d                     (img_d),
        .img_fv                    (img_fv),
        .img_lv                    (img_lv),
        .mem                       (wr_if),
        .status_capture_done       (status_capture_done),
        .status_capture_word_count (status_capture_word_count),
        .status_highlight_count    (status_highlight_count),
        .status_shadow_count       (status_shadow_count)
    );

    readout_reader u_reader (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .cmd_readout     (cmd_readout),
        .cmd_ram_block   (cmd_ram_block),
        .mem             (rd_if),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .readout_trigger (readout_trigger)
    );

    // ==============================
    // Shared memory
    // ==============================
    frame_mem_arbiter u_arbiter (
        .clk         (clk),
        .readout_rst (readout_rst),
        .wr_port     (wr_if),
        .rd_port     (rd_if),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_block   (mem_block),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

    frame_mem u_mem (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_block (mem_block),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_img_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "img_consts.svh"

module tb_img_controller;
    import img_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int W             = `IMG_FRAME_WIDTH;
    localparam int H             = `IMG_FRAME_HEIGHT;
    localparam int HDR           = `IMG_HEADER_WORDS;
    localparam int NPIX          = W * H;
    localparam int WORDS         = `IMG_WORD_COUNT;
    localparam int FV_LEAD       = 2;
    localparam int LINE_GAP      = 3;
    localparam int FRAME_GAP     = 5;
    localparam int FRAME_CYCLES  = FV_LEAD + H * (W + LINE_GAP) + FRAME_GAP;
    localparam int WORD_TIMEOUT  = 64;
    localparam int DONE_TIMEOUT  = 32;
    localparam int WORD_BUDGET   = 16;
    // Three frames captured, four readouts
    localparam int WATCHDOG_CYCLES = 20 + 3 * (FRAME_CYCLES + 40) +
                                     4 * (WORDS * WORD_BUDGET + 20) + 100;

    logic        clk;
    logic        readout_rst;
    logic        cmd_capture;
    logic        cmd_readout;
    block_t      cmd_ram_block;
    skip_t       cmd_skip_count;
    header_t     cmd_header;
    pixel_t      img_d;
    logic        img_fv;
    logic        img_lv;
    logic        readout_trigger;
    logic        readout_start;
    logic        readout_ready;
    word_t       readout_data;
    logic        status_capture_done;
    word_count_t status_capture_word_count;
    stat_count_t status_highlight_count;
    stat_count_t status_shadow_count;

    integer      seed = 78574;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    // Pixel frames to send and the image expected in each block
    pixel_t      frames [2][NPIX];
    word_t       exp_img [2][WORDS];

    img_controller uut (
        .clk                       (clk),
        .readout_rst               (readout_rst),
        .cmd_capture               (cmd_capture),
        .cmd_readout               (cmd_readout),
        .cmd_ram_block             (cmd_ram_block),
        .cmd_skip_count            (cmd_skip_count),
        .cmd_header                (cmd_header),
        .img_d                     (img_d),
        .img_fv                    (img_fv),
        .img_lv                    (img_lv),
        .readout_trigger           (readout_trigger),
        .readout_start             (readout_start),
        .readout_ready             (readout_ready),
        .readout_data              (readout_data),
        .status_capture_done       (status_capture_done),
        .status_capture_word_count (status_capture_word_count),
        .status_highlight_count    (status_highlight_count),
        .status_shadow_count       (status_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // A word waiting for its trigger stays presented
    ready_held: assert property (@(posedge clk) disable iff (!readout_rst)
        readout_ready && !readout_trigger |=> readout_ready)
    else begin
        errors++;
        $display("readout_ready dropped before its word was consumed");
    end

    // ==============================
    // Checks and reporting
    // ==============================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", tests_run, test_name,
                     errors - errors_at_start);
        end else begin
            $display("Test %0d %s: ok", tests_run, test_name);
        end
    endtask

    // ==============================
    // Reference model
    // ==============================
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    // Random frame with extremes forced on the 4x4 subsample grid
    task automatic fill_frame(input int idx, input int variant);
        logic [31:0] rnd;
        for (int i = 0; i < NPIX; i++) begin
            rnd = $random(seed);
            frames[idx][i] = rnd[11:0];
        end
        if (variant == 0) begin
            frames[idx][0] = 12'hFFF;
            frames[idx][4] = 12'h010;
        end else begin
            frames[idx][0] = 12'hFE0;
            frames[idx][4] = 12'hFFF;
        end
        // Off the grid, must not count
        frames[idx][W] = 12'hFFF;
        frames[idx][1] = 12'h000;
    endtask

    task automatic count_stats(input int idx, output stat_count_t hi, output stat_count_t sh);
        pixel_t px;
        hi = '0;
        sh = '0;
        for (int r = 0; r < H; r += 4) begin
            for (int c = 0; c < W; c += 4) begin
                px = frames[idx][r * W + c];
                if (&px[11 -: `IMG_STAT_MASK_BITS]) begin
                    hi = hi + 1'b1;
                end else if (px[11 -: `IMG_STAT_MASK_BITS] == '0) begin
                    sh = sh + 1'b1;
                end
            end
        end
    endtask

    task automatic build_expected(input block_t blk, input header_t hdr, input int idx);
        pixel_t px;
        word_t  w;
        int     a;
        int     b;
        for (int i = 0; i < HDR; i++) begin
            exp_img[blk][i] = hdr[(HDR - 1 - i) * 16 +: 16];
        end
        for (int i = 0; i < NPIX; i++) begin
            px = frames[idx][i];
            exp_img[blk][HDR + i] = {px[7:0], 4'h0, px[11:8]};
        end
        // Fletcher-32 over the little-endian view of every word before it
        a = 0;
        b = 0;
        for (int i = 0; i < HDR + NPIX; i++) begin
            w = swap_bytes(exp_img[blk][i]);
            a = (a + int'(w)) % 65535;
            b = (b + a) % 65535;
        end
        exp_img[blk][HDR + NPIX]     = swap_bytes(word_t'(a));
        exp_img[blk][HDR + NPIX + 1] = swap_bytes(word_t'(b));
    endtask

    // ==============================
    // Stimulus
    // ==============================
    task automatic send_frame(input int idx);
        img_fv = 1'b1;
        repeat (FV_LEAD) @(negedge clk);
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                img_lv = 1'b1;
                img_d  = frames[idx][r * W + c];
                @(negedge clk);
            end
            img_lv = 1'b0;
            img_d  = '0;
            repeat (LINE_GAP) @(negedge clk);
        end
        img_fv = 1'b0;
        repeat (FRAME_GAP) @(negedge clk);
    endtask

    task automatic run_capture(input block_t blk, input skip_t skip, input header_t hdr);
        logic        done_before;
        int          n;
        stat_count_t exp_hi;
        stat_count_t exp_sh;
        @(negedge clk);
        done_before    = status_capture_done;
        cmd_ram_block  = blk;
        cmd_skip_count = skip;
        cmd_header     = hdr;
        cmd_capture    = !cmd_capture;
        repeat (8) @(negedge clk);
        for (int f = 0; f <= int'(skip); f++) begin
            send_frame(f);
        end
        n = 0;
        while (status_capture_done == done_before && n < DONE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        check_true(status_capture_done != done_before,
                   "status_capture_done did not toggle after the frame");
        build_expected(blk, hdr, int'(skip));
        count_stats(int'(skip), exp_hi, exp_sh);
        check_value("status_capture_word_count", 32'(status_capture_word_count), WORDS);
        check_value("status_highlight_count", 32'(status_highlight_count), 32'(exp_hi));
        check_value("status_shadow_count", 32'(status_shadow_count), 32'(exp_sh));
    endtask

    task automatic run_readout(input block_t blk, input bit gaps);
        logic        start_before;
        logic [31:0] rnd;
        int          idx;
        int          wait_cycles;
        bit          checked;
        word_t       held;
        @(negedge clk);
        start_before    = readout_start;
        cmd_ram_block   = blk;
        cmd_readout     = !cmd_readout;
        readout_trigger = 1'b0;
        @(negedge clk);
        check_true(readout_start != start_before, "readout_start did not toggle");
        idx         = 0;
        wait_cycles = 0;
        checked     = 1'b0;
        while (idx < WORDS) begin
            @(negedge clk);
            if (readout_ready) begin
                if (!checked) begin
                    check_value($sformatf("readout_data[%0d]", idx), 32'(readout_data),
                                32'(exp_img[blk][idx]));
                    held    = readout_data;
                    checked = 1'b1;
                end else begin
                    check_value("readout_data (held)", 32'(readout_data), 32'(held));
                end
            end else begin
                wait_cycles++;
                if (wait_cycles > WORD_TIMEOUT) begin
                    check_true(1'b0, $sformatf("Word %0d never became ready", idx));
                    readout_trigger = 1'b0;
                    return;
                end
            end
            rnd             = $random(seed);
            readout_trigger = gaps ? (rnd[1:0] == 2'b00) : 1'b1;
            if (readout_ready && readout_trigger) begin
                idx++;
                checked     = 1'b0;
                wait_cycles = 0;
            end
        end
        // Nothing more after the last word
        repeat (10) begin
            @(negedge clk);
            check_true(!readout_ready, "readout_ready rose after the last word");
        end
        readout_trigger = 1'b0;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        readout_rst     = 1'b0;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_ram_block   = '0;
        cmd_skip_count  = '0;
        cmd_header      = '0;
        img_d           = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        readout_rst = 1'b1;

        begin_test("state after reset");
        @(negedge clk);
        check_value("readout_ready", 32'(readout_ready), 0);
        check_value("readout_start", 32'(readout_start), 0);
        check_value("status_capture_done", 32'(status_capture_done), 0);
        check_value("status_capture_word_count", 32'(status_capture_word_count), 0);
        check_value("status_highlight_count", 32'(status_highlight_count), 0);
        check_value("status_shadow_count", 32'(status_shadow_count), 0);
        end_test();

        begin_test("capture into block 0");
        fill_frame(0, 0);
        run_capture(1'b0, 1'b0, 64'h1234_5678_9ABC_DEF0);
        end_test();

        begin_test("readout of block 0");
        run_readout(1'b0, 1'b0);
        end_test();

        begin_test("capture with one skipped frame");
        fill_frame(0, 1);
        fill_frame(1, 0);
        run_capture(1'b1, 1'b1, 64'hFFFF_0001_A5A5_8000);
        run_readout(1'b1, 1'b0);
        end_test();

        begin_test("block 0 kept after block 1 capture");
        run_readout(1'b0, 1'b0);
        end_test();

        begin_test("readout with trigger gaps");
        run_readout(1'b1, 1'b1);
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/img_pkg.sv
design/mem_port_if.sv
design/fletcher_checksum.sv
design/capture_writer.sv
design/readout_reader.sv
design/frame_mem_arbiter.sv
design/frame_mem.sv
design/img_controller.sv
testbench/tb_img_controller.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_img_controller
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
